//--- verilog/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define WORD_W 16
`define REG_ADDR_W 2
`define REG_COUNT 4

// opcodes
`define OP_BNE 4'd0
`define OP_BEQ 4'd1
`define OP_ADI 4'd4
`define OP_LHI 4'd6
`define OP_LWD 4'd7
`define OP_SWD 4'd8
`define OP_JMP 4'd9
`define OP_NOP 4'd13
`define OP_RTYPE 4'd15

// function codes under OP_RTYPE
`define FN_ADD 6'd0
`define FN_SUB 6'd1
`define FN_AND 6'd2
`define FN_ORR 6'd3
`define FN_WWD 6'd28
`define FN_HLT 6'd29

`define INSTR_NOP 16'hd000

`define F_OP 15:12
`define F_RS 11:10
`define F_RT 9:8
`define F_RD 7:6
`define F_FN 5:0
`define F_IMM 7:0
`define F_TGT 11:0

`endif

//--- verilog/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	typedef enum logic [2:0] {
		ADD,
		SUB,
		AND,
		OR,
		LHI // immediate moved into the upper byte
	} alu_op_t;

	// all zeros is a bubble
	typedef struct packed {
		logic valid;
		alu_op_t alu_op;
		logic alu_src; // operand b from imm_ext
		logic mem_read;
		logic mem_write;
		logic reg_write;
		logic is_branch;
		logic branch_eq; // BEQ when set, BNE otherwise
		logic is_jump;
		logic is_wwd;
		logic is_hlt;
	} ctrl_t;

	typedef struct packed {
		ctrl_t ctrl;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t dest;
		word_t imm_ext; // sign-extended, or the jump target field for JMP
	} decoded_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t pc;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t dest;
		word_t rs_val;
		word_t rt_val;
		word_t imm_ext;
	} id_ex_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t alu_result;
		word_t store_data; // rs for WWD, rt otherwise
		reg_addr_t dest;
	} ex_mem_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t result;
		word_t wwd_data;
		reg_addr_t dest;
	} mem_wb_t;

	typedef enum logic [1:0] {
		REG,
		FROM_MEM,
		FROM_WB
	} fwd_sel_t;

endpackage

//--- verilog/decoder.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module decoder import cpu_pkg::*; (
	input word_t instr,
	output decoded_t dec
);

	logic [3:0] opcode;
	logic [5:0] fn;

	assign opcode = instr[`F_OP];
	assign fn = instr[`F_FN];

	always_comb begin
		dec = '0;
		dec.rs = instr[`F_RS];
		dec.rt = instr[`F_RT];
		dec.dest = instr[`F_RD];
		dec.imm_ext = {{(`WORD_W-8){instr[7]}}, instr[`F_IMM]};

		case (opcode)
			`OP_RTYPE: begin
				case (fn)
					`FN_ADD, `FN_SUB, `FN_AND, `FN_ORR: begin
						dec.ctrl.valid = 1'b1;
						dec.ctrl.reg_write = 1'b1;
						dec.ctrl.alu_op = alu_op_t'({1'b0, fn[1:0]}); // fn order matches alu_op_t
					end
					`FN_WWD: begin
						dec.ctrl.valid = 1'b1;
						dec.ctrl.is_wwd = 1'b1;
					end
					`FN_HLT: begin
						dec.ctrl.valid = 1'b1;
						dec.ctrl.is_hlt = 1'b1;
					end
					default: dec.ctrl = '0;
				endcase
			end
			`OP_ADI, `OP_LHI, `OP_LWD: begin
				dec.ctrl.valid = 1'b1;
				dec.ctrl.alu_src = 1'b1;
				dec.ctrl.reg_write = 1'b1;
				dec.ctrl.mem_read = (opcode == `OP_LWD);
				dec.ctrl.alu_op = (opcode == `OP_LHI) ? LHI : ADD;
				dec.dest = instr[`F_RT];
			end
			`OP_SWD: begin
				dec.ctrl.valid = 1'b1;
				dec.ctrl.alu_src = 1'b1;
				dec.ctrl.mem_write = 1'b1;
			end
			`OP_BNE, `OP_BEQ: begin
				dec.ctrl.valid = 1'b1;
				dec.ctrl.is_branch = 1'b1;
				dec.ctrl.branch_eq = (opcode == `OP_BEQ);
			end
			`OP_JMP: begin
				dec.ctrl.valid = 1'b1;
				dec.ctrl.is_jump = 1'b1;
				dec.imm_ext = {{(`WORD_W-12){1'b0}}, instr[`F_TGT]}; // page bits added in EX
			end
			`OP_NOP: dec.ctrl = '0;
			default: dec.ctrl = '0; // unknown opcode
		endcase
	end

endmodule

//--- verilog/register_file.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module register_file import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	input reg_addr_t rs_addr,
	input reg_addr_t rt_addr,
	input logic wr_en,
	input reg_addr_t wr_addr,
	input word_t wr_data,
	output word_t rs_val,
	output word_t rt_val
);

	word_t regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// WB and ID share a cycle, so the new value bypasses the array
	assign rs_val = (wr_en && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
	assign rt_val = (wr_en && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

//--- verilog/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit import cpu_pkg::*; (
	input reg_addr_t id_rs,
	input reg_addr_t id_rt,
	input id_ex_t ex,
	input ex_mem_t mem,
	input mem_wb_t wb,
	output logic stall,
	output fwd_sel_t fwd_a,
	output fwd_sel_t fwd_b
);

	logic load_in_ex;

	assign load_in_ex = ex.ctrl.valid && ex.ctrl.mem_read;

	// loaded word is only available from WB, one cycle too late for EX
	assign stall = load_in_ex && (ex.dest == id_rs || ex.dest == id_rt);

	always_comb begin
		if (mem.ctrl.reg_write && mem.dest == ex.rs) begin
			fwd_a = FROM_MEM; // younger result wins
		end else if (wb.ctrl.reg_write && wb.dest == ex.rs) begin
			fwd_a = FROM_WB;
		end else begin
			fwd_a = REG;
		end

		if (mem.ctrl.reg_write && mem.dest == ex.rt) begin
			fwd_b = FROM_MEM;
		end else if (wb.ctrl.reg_write && wb.dest == ex.rt) begin
			fwd_b = FROM_WB;
		end else begin
			fwd_b = REG;
		end
	end

endmodule

//--- verilog/execute.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module execute import cpu_pkg::*; (
	input id_ex_t ex,
	input word_t op_a,
	input word_t op_b,
	output ex_mem_t result,
	output logic redirect,
	output word_t target
);

	word_t alu_b;
	word_t alu_out;
	logic taken;

	assign alu_b = ex.ctrl.alu_src ? ex.imm_ext : op_b;

	always_comb begin
		case (ex.ctrl.alu_op)
			ADD: alu_out = op_a + alu_b;
			SUB: alu_out = op_a - alu_b;
			AND: alu_out = op_a & alu_b;
			OR: alu_out = op_a | alu_b;
			LHI: alu_out = {alu_b[7:0], 8'h00};
			default: alu_out = '0;
		endcase
	end

	assign taken = ex.ctrl.is_branch && ((op_a == op_b) == ex.ctrl.branch_eq);
	assign redirect = ex.ctrl.valid && (taken || ex.ctrl.is_jump);

	// JMP stays in the current 4K page
	assign target = ex.ctrl.is_jump ? {ex.pc[`WORD_W-1:12], ex.imm_ext[`F_TGT]}
		: ex.pc + word_t'(1) + ex.imm_ext;

	always_comb begin
		result.ctrl = ex.ctrl;
		result.alu_result = alu_out;
		result.store_data = ex.ctrl.is_wwd ? op_a : op_b;
		result.dest = ex.dest;
	end

endmodule

//--- verilog/pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic reset,
	input logic hold,
	input logic flush,
	input payload_t d,
	output payload_t q
);

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			q <= '0; // bubble
		end else if (!hold) begin
			q <= d;
		end
	end

	// a stage is either kept or squashed, never both at once
	a_hold_flush: assert property (@(posedge clk) disable iff (reset) !(hold && flush));

endmodule

//--- verilog/cpu.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	output word_t instr_addr,
	input word_t instr_data,
	output logic data_read,
	output logic data_write,
	output word_t data_addr,
	output word_t data_wdata,
	input word_t data_rdata,
	output word_t output_port,
	output word_t num_inst,
	output logic is_halted
);

	word_t pc;
	word_t if_pc;
	word_t if_instr;
	logic halting;
	logic halted_q;
	logic stop;

	decoded_t dec;
	word_t rs_val;
	word_t rt_val;
	logic stall;
	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;
	word_t op_a;
	word_t op_b;
	logic redirect;
	word_t target;

	id_ex_t id_ex_d;
	id_ex_t ex_q;
	ex_mem_t ex_res;
	ex_mem_t mem_q;
	mem_wb_t mem_wb_d;
	mem_wb_t wb_q;

	// HLT in EX freezes fetch from then on
	assign stop = ex_q.ctrl.is_hlt || halting;
	assign instr_addr = pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			halting <= 1'b0;
		end else begin
			if (ex_q.ctrl.is_hlt)
				halting <= 1'b1;
			if (redirect)
				pc <= target;
			else if (!stall && !stop)
				pc <= pc + word_t'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (reset || redirect || stop) begin
			if_pc <= '0;
			if_instr <= `INSTR_NOP;
		end else if (!stall) begin
			if_pc <= pc;
			if_instr <= instr_data;
		end
	end

	decoder u_decoder (
		.instr(if_instr),
		.dec(dec)
	);

	register_file u_regs (
		.clk(clk),
		.reset(reset),
		.rs_addr(dec.rs),
		.rt_addr(dec.rt),
		.wr_en(wb_q.ctrl.reg_write),
		.wr_addr(wb_q.dest),
		.wr_data(wb_q.result),
		.rs_val(rs_val),
		.rt_val(rt_val)
	);

	always_comb begin
		id_ex_d.ctrl = dec.ctrl;
		id_ex_d.pc = if_pc;
		id_ex_d.rs = dec.rs;
		id_ex_d.rt = dec.rt;
		id_ex_d.dest = dec.dest;
		id_ex_d.rs_val = rs_val;
		id_ex_d.rt_val = rt_val;
		id_ex_d.imm_ext = dec.imm_ext;
	end

	pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
		.clk(clk),
		.reset(reset),
		.hold(1'b0),
		.flush(redirect || stall || stop), // load-use bubble or squash
		.d(id_ex_d),
		.q(ex_q)
	);

	hazard_unit u_hazard (
		.id_rs(dec.rs),
		.id_rt(dec.rt),
		.ex(ex_q),
		.mem(mem_q),
		.wb(wb_q),
		.stall(stall),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

	always_comb begin
		case (fwd_a)
			FROM_MEM: op_a = mem_q.alu_result;
			FROM_WB: op_a = wb_q.result;
			default: op_a = ex_q.rs_val;
		endcase
		case (fwd_b)
			FROM_MEM: op_b = mem_q.alu_result;
			FROM_WB: op_b = wb_q.result;
			default: op_b = ex_q.rt_val;
		endcase
	end

	execute u_execute (
		.ex(ex_q),
		.op_a(op_a),
		.op_b(op_b),
		.result(ex_res),
		.redirect(redirect),
		.target(target)
	);

	pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
		.clk(clk),
		.reset(reset),
		.hold(1'b0),
		.flush(1'b0),
		.d(ex_res),
		.q(mem_q)
	);

	assign data_read = mem_q.ctrl.mem_read;
	assign data_write = mem_q.ctrl.mem_write;
	assign data_addr = mem_q.alu_result;
	assign data_wdata = mem_q.store_data;

	always_comb begin
		mem_wb_d.ctrl = mem_q.ctrl;
		mem_wb_d.result = mem_q.ctrl.mem_read ? data_rdata : mem_q.alu_result;
		mem_wb_d.wwd_data = mem_q.store_data;
		mem_wb_d.dest = mem_q.dest;
	end

	pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
		.clk(clk),
		.reset(reset),
		.hold(1'b0),
		.flush(1'b0),
		.d(mem_wb_d),
		.q(wb_q)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			output_port <= '0;
			num_inst <= '0;
			halted_q <= 1'b0;
		end else begin
			if (wb_q.ctrl.is_wwd)
				output_port <= wb_q.wwd_data;
			if (wb_q.ctrl.valid)
				num_inst <= num_inst + word_t'(1); // bubbles never count
			if (wb_q.ctrl.is_hlt)
				halted_q <= 1'b1;
		end
	end

	assign is_halted = halted_q || wb_q.ctrl.is_hlt;

	// the load-use stall keeps a load address from being forwarded as data
	a_no_load_fwd: assert property (@(posedge clk) disable iff (reset)
		ex_q.ctrl.valid && (fwd_a == FROM_MEM || fwd_b == FROM_MEM) |-> !mem_q.ctrl.mem_read);

	// nothing fetched behind HLT ever retires
	a_halt_drain: assert property (@(posedge clk) disable iff (reset)
		halted_q |-> !wb_q.ctrl.valid);

endmodule

//--- bench/isa_model.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

function automatic word_t enc_r(logic [5:0] fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd);
	return {`OP_RTYPE, rs, rt, rd, fn};
endfunction

function automatic word_t enc_i(logic [3:0] op, reg_addr_t rs, reg_addr_t rt, logic [7:0] imm);
	return {op, rs, rt, imm};
endfunction

// initial data memory contents, every address bit matters
function automatic word_t fill_word(word_t a);
	return {a[7:0], a[15:8]} ^ (a * 16'd3) ^ 16'h5a5a;
endfunction

// forward branches and jumps only, so every program reaches its HLT
task automatic gen_program();
	logic [31:0] r;
	int pos;
	int halt_pos;
	int room;
	for (int i = 0; i < 256; i++)
		imem[i] = `INSTR_NOP;
	pos = 0;
	for (int i = 0; i < 4; i++) begin
		r = next_rand();
		imem[pos] = enc_i(`OP_LHI, 2'd0, reg_addr_t'(i), r[7:0]);
		imem[pos + 1] = enc_i(`OP_ADI, reg_addr_t'(i), reg_addr_t'(i), r[15:8]);
		pos += 2;
	end
	halt_pos = pos + 24 + int'(next_rand() % 24);
	while (pos < halt_pos) begin
		r = next_rand();
		room = halt_pos - pos - 1; // farthest target is the HLT itself
		case (int'(r[31:24]) % 10)
			0, 1: imem[pos] = enc_r({4'd0, r[9:8]}, r[1:0], r[3:2], r[5:4]);
			2: imem[pos] = enc_i(`OP_ADI, r[1:0], r[3:2], r[23:16]);
			3: imem[pos] = enc_i(`OP_LHI, 2'd0, r[3:2], r[23:16]);
			4: imem[pos] = enc_i(`OP_SWD, r[1:0], r[3:2], r[23:16]);
			5: begin
				imem[pos] = enc_i(`OP_LWD, r[1:0], r[3:2], r[23:16]);
				if (room > 0) begin
					pos++;
					imem[pos] = enc_r(`FN_WWD, r[3:2], 2'd0, 2'd0); // uses the load at once
				end
			end
			6: imem[pos] = enc_i(r[8] ? `OP_BEQ : `OP_BNE, r[1:0], r[3:2],
				8'(int'(r[23:16]) % (room + 1)));
			7: imem[pos] = {`OP_JMP, 12'(pos + 1 + int'(r[23:16]) % (room + 1))};
			default: imem[pos] = enc_r(`FN_WWD, r[1:0], 2'd0, 2'd0);
		endcase
		pos++;
	end
	imem[halt_pos] = enc_r(`FN_HLT, 2'd0, 2'd0, 2'd0);
endtask

// one instruction at a time, no pipeline
task automatic run_model();
	word_t regs [4];
	word_t pc;
	word_t next_pc;
	word_t instr;
	word_t a;
	word_t b;
	word_t imm;
	word_t out;
	logic done;
	for (int i = 0; i < 4; i++)
		regs[i] = '0;
	for (int i = 0; i < 65536; i++)
		model_dmem[i] = fill_word(word_t'(i));
	exp_out.delete();
	exp_st_addr.delete();
	exp_st_data.delete();
	exp_count = 0;
	pc = '0;
	out = '0;
	done = 1'b0;
	while (!done && exp_count < 1000) begin
		instr = imem[pc[7:0]];
		a = regs[instr[`F_RS]];
		b = regs[instr[`F_RT]];
		imm = {{8{instr[7]}}, instr[`F_IMM]};
		next_pc = pc + 16'd1;
		exp_count++;
		case (instr[`F_OP])
			`OP_RTYPE: begin
				case (instr[`F_FN])
					`FN_ADD: regs[instr[`F_RD]] = a + b;
					`FN_SUB: regs[instr[`F_RD]] = a - b;
					`FN_AND: regs[instr[`F_RD]] = a & b;
					`FN_ORR: regs[instr[`F_RD]] = a | b;
					`FN_WWD: if (a != out) begin
						out = a;
						exp_out.push_back(a); // the port only shows changes
					end
					`FN_HLT: done = 1'b1;
					default: ;
				endcase
			end
			`OP_ADI: regs[instr[`F_RT]] = a + imm;
			`OP_LHI: regs[instr[`F_RT]] = {instr[`F_IMM], 8'h00};
			`OP_LWD: regs[instr[`F_RT]] = model_dmem[a + imm];
			`OP_SWD: begin
				model_dmem[a + imm] = b;
				exp_st_addr.push_back(a + imm);
				exp_st_data.push_back(b);
			end
			`OP_BNE: if (a != b) next_pc = next_pc + imm;
			`OP_BEQ: if (a == b) next_pc = next_pc + imm;
			`OP_JMP: next_pc = {pc[15:12], instr[`F_TGT]};
			default: ;
		endcase
		pc = next_pc;
	end
endtask

`endif

//--- bench/tb_cpu.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module tb_cpu import cpu_pkg::*; ();

	localparam int NUM_PROGS = 8;
	localparam int HALT_TIMEOUT = 3000; // cycles per program

	logic clk = 1'b0;
	logic reset;
	word_t instr_addr;
	word_t instr_data;
	logic data_read;
	logic data_write;
	word_t data_addr;
	word_t data_wdata;
	word_t data_rdata;
	word_t output_port;
	word_t num_inst;
	logic is_halted;

	word_t imem [256];
	word_t dmem [65536];
	word_t model_dmem [65536];
	word_t exp_out [$];
	word_t exp_st_addr [$];
	word_t exp_st_data [$];
	int exp_count;
	logic [31:0] rng_state;
	int mismatches;
	int failures;
	logic running;
	word_t last_out;
	string tag;

	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	`include "isa_model.svh"

	always #4 clk = ~clk;

	cpu dut (
		.clk(clk),
		.reset(reset),
		.instr_addr(instr_addr),
		.instr_data(instr_data),
		.data_read(data_read),
		.data_write(data_write),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_rdata(data_rdata),
		.output_port(output_port),
		.num_inst(num_inst),
		.is_halted(is_halted)
	);

	task automatic check_word(string name, word_t expected, word_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
			mismatches++;
		end
	endtask

	task automatic check_flag(string name, logic expected, logic actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %b actual %b", name, expected, actual);
			mismatches++;
		end
	endtask

	// memories answer 1 ns after the edge since both addresses come from registers
	always @(posedge clk) begin
		#1;
		instr_data = (instr_addr < 16'd256) ? imem[instr_addr[7:0]] : `INSTR_NOP;
		data_rdata = dmem[data_addr];
	end

	always @(negedge clk) begin
		if (running && data_write) begin
			if (exp_st_addr.size() == 0) begin
				$display("%s: store to %h that the model never made", tag, data_addr);
				failures++;
			end else begin
				check_word({tag, " store addr"}, exp_st_addr.pop_front(), data_addr);
				check_word({tag, " store data"}, exp_st_data.pop_front(), data_wdata);
			end
			dmem[data_addr] = data_wdata;
		end
		if (running && output_port != last_out) begin
			if (exp_out.size() == 0) begin
				$display("%s: output_port changed to %h with no WWD left in the model",
					tag, output_port);
				failures++;
			end else begin
				check_word({tag, " output_port"}, exp_out.pop_front(), output_port);
			end
			last_out = output_port;
		end
	end

	initial begin
		logic timed_out;
		int cycles;
		reset = 1'b1;
		instr_data = `INSTR_NOP;
		data_rdata = '0;
		rng_state = 32'ha197;
		mismatches = 0;
		failures = 0;
		running = 1'b0;
		timed_out = 1'b0;
		for (int p = 0; p < NUM_PROGS && !timed_out; p++) begin
			tag = $sformatf("prog%0d", p);
			gen_program();
			run_model();
			for (int i = 0; i < 65536; i++)
				dmem[i] = fill_word(word_t'(i));
			last_out = '0;
			repeat (5) @(posedge clk);
			#1;
			check_word({tag, " reset output_port"}, '0, output_port);
			check_word({tag, " reset num_inst"}, '0, num_inst);
			check_word({tag, " reset instr_addr"}, '0, instr_addr);
			check_flag({tag, " reset is_halted"}, 1'b0, is_halted);
			check_flag({tag, " reset data_read"}, 1'b0, data_read);
			check_flag({tag, " reset data_write"}, 1'b0, data_write);
			reset = 1'b0;
			running = 1'b1;
			cycles = 0;
			while (!is_halted && cycles < HALT_TIMEOUT) begin
				@(posedge clk);
				#1;
				cycles++;
			end
			if (!is_halted) begin
				$display("%s: is_halted never rose within %0d cycles", tag, HALT_TIMEOUT);
				failures++;
				timed_out = 1'b1;
			end else begin
				repeat (3) begin
					@(posedge clk);
					#1;
					check_flag({tag, " is_halted held"}, 1'b1, is_halted);
				end
				check_word({tag, " num_inst"}, word_t'(exp_count), num_inst);
				if (exp_out.size() != 0 || exp_st_addr.size() != 0) begin
					$display("%s: %0d output changes and %0d stores never seen",
						tag, exp_out.size(), exp_st_addr.size());
					failures++;
				end
			end
			running = 1'b0;
			reset = 1'b1;
		end
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+verilog
+incdir+bench
verilog/cpu_pkg.sv
verilog/decoder.sv
verilog/register_file.sv
verilog/hazard_unit.sv
verilog/execute.sv
verilog/pipe_reg.sv
verilog/cpu.sv
bench/tb_cpu.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_cpu
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -j 0
PASS_MSG ?= all tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verilog/*.svh bench/*.svh)
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
